// File: design/axiLitePkg.sv
package axiLitePkg;

  // bus widths of the AXI4-Lite port
  localparam int addrWidth = 32;
  localparam int dataWidth = 32;
  localparam int strbWidth = dataWidth / 8;

  // only OKAY and SLVERR are ever seen on this bus
  localparam logic [1:0] respOkay   = 2'b00;
  localparam logic [1:0] respSlvErr = 2'b10;

endpackage : axiLitePkg

// File: design/masterReqPkg.sv
package masterReqPkg;

  localparam int queueDepth  = 4;
  localparam int creditWidth = $clog2(queueDepth + 1); // counts 0 to queueDepth
  localparam int ptrWidth    = $clog2(queueDepth);

  // field order gives addr in the top bits, strb in the bottom ones
  typedef struct packed {
    logic [axiLitePkg::addrWidth-1:0] addr;
    logic [axiLitePkg::dataWidth-1:0] data;
    logic [axiLitePkg::strbWidth-1:0] strb;
  } wrReqT;

  typedef struct packed {
    logic [axiLitePkg::addrWidth-1:0] addr;
  } rdReqT;

endpackage : masterReqPkg

// File: design/creditFifo.sv
`timescale 1ns/1ps

module creditFifo #(
  parameter type payloadT = logic
) (
  input  logic    aclk,
  input  logic    reset,
  input  logic    push,
  input  payloadT pushData,
  input  logic    pop,
  output payloadT head,
  output logic    notEmpty,
  output logic    credit
);
  import masterReqPkg::*;

  payloadT                storage [queueDepth];
  logic [ptrWidth-1:0]    wrPtr;
  logic [ptrWidth-1:0]    rdPtr;
  logic [creditWidth-1:0] count;

  always_ff @(posedge aclk) begin
    if (push) begin
      storage[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      wrPtr  <= '0;
      rdPtr  <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      credit <= pop; // each freed slot goes back to the requester one cycle later
      if (push) begin
        wrPtr <= (wrPtr == ptrWidth'(queueDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == ptrWidth'(queueDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign notEmpty = (count != '0);
  assign head     = storage[rdPtr];

  // a push into a full queue means the requester spent a credit it never had
  pushWhenFull : assert property (@(posedge aclk) disable iff (reset)
    push |-> (count != creditWidth'(queueDepth)))
    else $error("creditFifo push while full, credit rule broken");

  popWhenEmpty : assert property (@(posedge aclk) disable iff (reset)
    pop |-> notEmpty)
    else $error("creditFifo pop while empty");

endmodule : creditFifo

// File: design/writeChannel.sv
`timescale 1ns/1ps

module writeChannel (
  input  logic                             aclk,
  input  logic                             reset,
  input  logic                             load,
  input  masterReqPkg::wrReqT              loadReq,
  output logic                             awvalid,
  output logic [axiLitePkg::addrWidth-1:0] awaddr,
  input  logic                             awready,
  output logic                             wvalid,
  output logic [axiLitePkg::dataWidth-1:0] wdata,
  output logic [axiLitePkg::strbWidth-1:0] wstrb,
  input  logic                             wready,
  output logic                             bready,
  input  logic                             bvalid,
  input  logic [1:0]                       bresp,
  output logic                             done,
  output logic [1:0]                       doneResp
);
  import masterReqPkg::*;

  wrReqT req;
  logic  awLeft;
  logic  wLeft;
  logic  lastAccept;

  // the request stays here until the B handshake, AW and W both read from it
  always_ff @(posedge aclk) begin
    if (load) begin
      req <= loadReq;
    end
    if (bvalid && bready) begin
      doneResp <= bresp;
    end
  end

  assign awaddr = req.addr;
  assign wdata  = req.data;
  assign wstrb  = req.strb;

  assign awLeft     = awvalid && !awready;
  assign wLeft      = wvalid && !wready;
  assign lastAccept = (awvalid || wvalid) && !awLeft && !wLeft; // final of AW and W this edge

  always_ff @(posedge aclk) begin
    if (reset) begin
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (load) begin
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
      end else begin
        if (awvalid && awready) awvalid <= 1'b0;
        if (wvalid && wready) wvalid <= 1'b0;
      end
      if (lastAccept) begin
        bready <= 1'b1;
      end else if (bvalid && bready) begin
        bready <= 1'b0;
        done   <= 1'b1;
      end
    end
  end

  awaddrStable : assert property (@(posedge aclk) disable iff (reset)
    awLeft |=> awvalid && $stable(awaddr))
    else $error("awaddr changed or awvalid dropped before awready");

endmodule : writeChannel

// File: design/readChannel.sv
`timescale 1ns/1ps

module readChannel (
  input  logic                             aclk,
  input  logic                             reset,
  input  logic                             load,
  input  logic [axiLitePkg::addrWidth-1:0] loadAddr,
  output logic                             arvalid,
  output logic [axiLitePkg::addrWidth-1:0] araddr,
  input  logic                             arready,
  output logic                             rready,
  input  logic                             rvalid,
  input  logic [axiLitePkg::dataWidth-1:0] rdata,
  input  logic [1:0]                       rresp,
  output logic                             done,
  output logic [axiLitePkg::dataWidth-1:0] doneData,
  output logic [1:0]                       doneResp
);

  always_ff @(posedge aclk) begin
    if (load) begin
      araddr <= loadAddr;
    end
    if (rvalid && rready) begin
      doneData <= rdata;
      doneResp <= rresp;
    end
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      arvalid <= 1'b0;
      rready  <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (load) begin
        arvalid <= 1'b1;
      end else if (arvalid && arready) begin
        arvalid <= 1'b0;
        rready  <= 1'b1; // data phase opens right after the address is taken
      end
      if (rvalid && rready) begin
        rready <= 1'b0;
        done   <= 1'b1;
      end
    end
  end

  arvalidHeld : assert property (@(posedge aclk) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("arvalid dropped or araddr changed without arready");

endmodule : readChannel

// File: design/masterControl.sv
`timescale 1ns/1ps

module masterControl (
  input  logic                             aclk,
  input  logic                             reset,
  input  logic                             wrNotEmpty,
  input  logic                             rdNotEmpty,
  output logic                             wrPop,
  output logic                             rdPop,
  output logic                             wrLoad,
  output logic                             rdLoad,
  input  logic                             wrDone,
  input  logic                             rdDone,
  input  logic [1:0]                       wrResp,
  input  logic [1:0]                       rdResp,
  input  logic [axiLitePkg::dataWidth-1:0] rdData,
  output logic                             rspValid,
  output logic                             rspIsWrite,
  output logic [axiLitePkg::dataWidth-1:0] rspData,
  output logic [1:0]                       rspResp
);

  typedef enum logic [1:0] {
    idle      = 2'd0,
    busyWrite = 2'd1,
    busyRead  = 2'd2
  } stateT;

  stateT state;
  logic  lastWasWrite; // cleared by reset so the first pick is a write
  logic  pickWrite;
  logic  pickRead;

  // round robin between the two queues, the kind not served last wins a tie
  assign pickWrite = wrNotEmpty && (!rdNotEmpty || !lastWasWrite);
  assign pickRead  = rdNotEmpty && (!wrNotEmpty || lastWasWrite);

  assign wrPop  = (state == idle) && pickWrite;
  assign rdPop  = (state == idle) && pickRead;
  assign wrLoad = wrPop; // the popped head goes straight into the channel
  assign rdLoad = rdPop;

  always_ff @(posedge aclk) begin
    if (reset) begin
      state        <= idle;
      lastWasWrite <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (wrPop) begin
            state        <= busyWrite;
            lastWasWrite <= 1'b1;
          end else if (rdPop) begin
            state        <= busyRead;
            lastWasWrite <= 1'b0;
          end
        end
        busyWrite: if (wrDone) state <= idle;
        busyRead:  if (rdDone) state <= idle;
        default:   state <= idle;
      endcase
    end
  end

  // the channels already hold the captured response, so done passes straight out
  assign rspValid   = wrDone || rdDone;
  assign rspIsWrite = wrDone;
  assign rspData    = rdDone ? rdData : '0;
  assign rspResp    = wrDone ? wrResp : rdResp;

  // a done from a channel the sequencer did not start means both sides were busy
  singleBusy : assert property (@(posedge aclk) disable iff (reset)
    (wrDone |-> state == busyWrite) and (rdDone |-> state == busyRead))
    else $error("done from a channel that is not the active one");

endmodule : masterControl

// File: design/axiLiteMasterTop.sv
`timescale 1ns/1ps

module axiLiteMasterTop (
  input  logic                             aclk,
  input  logic                             reset,
  input  logic                             wrReqValid,
  input  logic [axiLitePkg::addrWidth-1:0] wrReqAddr,
  input  logic [axiLitePkg::dataWidth-1:0] wrReqData,
  input  logic [axiLitePkg::strbWidth-1:0] wrReqStrb,
  output logic                             wrCredit,
  input  logic                             rdReqValid,
  input  logic [axiLitePkg::addrWidth-1:0] rdReqAddr,
  output logic                             rdCredit,
  output logic                             rspValid,
  output logic                             rspIsWrite,
  output logic [axiLitePkg::dataWidth-1:0] rspData,
  output logic [1:0]                       rspResp,
  output logic                             awvalid,
  output logic [axiLitePkg::addrWidth-1:0] awaddr,
  output logic [2:0]                       awprot,
  input  logic                             awready,
  output logic                             wvalid,
  output logic [axiLitePkg::dataWidth-1:0] wdata,
  output logic [axiLitePkg::strbWidth-1:0] wstrb,
  input  logic                             wready,
  input  logic                             bvalid,
  input  logic [1:0]                       bresp,
  output logic                             bready,
  output logic                             arvalid,
  output logic [axiLitePkg::addrWidth-1:0] araddr,
  output logic [2:0]                       arprot,
  input  logic                             arready,
  input  logic                             rvalid,
  input  logic [axiLitePkg::dataWidth-1:0] rdata,
  input  logic [1:0]                       rresp,
  output logic                             rready
);
  import masterReqPkg::*;

  wrReqT                           wrPushData;
  wrReqT                           wrHead;
  rdReqT                           rdPushData;
  rdReqT                           rdHead;
  logic                            wrNotEmpty;
  logic                            rdNotEmpty;
  logic                            wrPop;
  logic                            rdPop;
  logic                            wrLoad;
  logic                            rdLoad;
  logic                            wrDone;
  logic                            rdDone;
  logic [1:0]                      wrResp;
  logic [1:0]                      rdResp;
  logic [axiLitePkg::dataWidth-1:0] rdData;

  assign wrPushData.addr = wrReqAddr;
  assign wrPushData.data = wrReqData;
  assign wrPushData.strb = wrReqStrb;
  assign rdPushData.addr = rdReqAddr;

  assign awprot = 3'b000; // unprivileged, secure, data access
  assign arprot = 3'b000;

  creditFifo #(.payloadT(wrReqT)) writeQueue (
    .aclk(aclk), .reset(reset), .push(wrReqValid), .pushData(wrPushData),
    .pop(wrPop), .head(wrHead), .notEmpty(wrNotEmpty), .credit(wrCredit)
  );

  creditFifo #(.payloadT(rdReqT)) readQueue (
    .aclk(aclk), .reset(reset), .push(rdReqValid), .pushData(rdPushData),
    .pop(rdPop), .head(rdHead), .notEmpty(rdNotEmpty), .credit(rdCredit)
  );

  writeChannel wrChannel (
    .aclk(aclk), .reset(reset), .load(wrLoad), .loadReq(wrHead),
    .awvalid(awvalid), .awaddr(awaddr), .awready(awready),
    .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
    .bready(bready), .bvalid(bvalid), .bresp(bresp),
    .done(wrDone), .doneResp(wrResp)
  );

  readChannel rdChannel (
    .aclk(aclk), .reset(reset), .load(rdLoad), .loadAddr(rdHead.addr),
    .arvalid(arvalid), .araddr(araddr), .arready(arready),
    .rready(rready), .rvalid(rvalid), .rdata(rdata), .rresp(rresp),
    .done(rdDone), .doneData(rdData), .doneResp(rdResp)
  );

  masterControl control (
    .aclk(aclk), .reset(reset),
    .wrNotEmpty(wrNotEmpty), .rdNotEmpty(rdNotEmpty),
    .wrPop(wrPop), .rdPop(rdPop), .wrLoad(wrLoad), .rdLoad(rdLoad),
    .wrDone(wrDone), .rdDone(rdDone), .wrResp(wrResp), .rdResp(rdResp),
    .rdData(rdData), .rspValid(rspValid), .rspIsWrite(rspIsWrite),
    .rspData(rspData), .rspResp(rspResp)
  );

endmodule : axiLiteMasterTop

// File: testbench/tbAxiLiteMaster.sv
`timescale 1ns/1ps

module tbAxiLiteMaster;
  import axiLitePkg::*;
  import masterReqPkg::*;

  localparam int memWords      = 64;
  localparam int errWord       = 48; // first word that answers SLVERR
  localparam int seedValue     = 32'h2354;
  localparam int rrPairs       = 8;
  localparam int pairTests     = 10;
  localparam int burstLen      = 40;
  localparam int errRequests   = 2;
  localparam int totalReqs     = 2 * rrPairs + 2 * pairTests + burstLen + errRequests;
  localparam int timeoutCycles = 200 * totalReqs;

  logic                 aclk;
  logic                 reset;
  logic                 wrReqValid, rdReqValid, wrCredit, rdCredit, rspValid, rspIsWrite;
  logic [addrWidth-1:0] wrReqAddr, rdReqAddr, awaddr, araddr;
  logic [dataWidth-1:0] wrReqData, rspData, wdata, rdata;
  logic [strbWidth-1:0] wrReqStrb, wstrb;
  logic [1:0]           rspResp, bresp, rresp;
  logic [2:0]           awprot, arprot;
  logic                 awvalid, awready, wvalid, wready, bvalid, bready;
  logic                 arvalid, arready, rvalid, rready;

  logic [dataWidth-1:0] slaveMem [memWords];
  logic [dataWidth-1:0] refMem [memWords];
  wrReqT                wrLog [$];
  rdReqT                rdLog [$];
  bit                   kindLog [$];
  int                   reqSeed = seedValue;
  int                   slaveSeed = seedValue ^ 32'h0000_ffff;
  int                   wrSpent, rdSpent, wrIssued, rdIssued; // issued copies are for the monitor
  int                   wrReturned, rdReturned, wrDoneCount, rdDoneCount;
  int                   errorCount, checkCount, testCount, cycleCount;
  bit                   rrCheck, rrExpectWrite, awHold, wHold, arHold, gotAw, gotW, gotAr;
  logic [addrWidth-1:0] awaddrLast, araddrLast, slvAwAddr, slvArAddr;
  logic [dataWidth-1:0] wdataLast, slvWData;
  logic [strbWidth-1:0] wstrbLast, slvWStrb;

  axiLiteMasterTop UUT (.*);

  function automatic logic [dataWidth-1:0] fillWord(input int idx);
    return 32'hC0DE0000 ^ (idx * 32'h00010203);
  endfunction

  // byte lanes with a strobe bit take the new data
  function automatic logic [dataWidth-1:0] mergeBytes(input logic [dataWidth-1:0] old,
      input logic [dataWidth-1:0] data, input logic [strbWidth-1:0] strb);
    logic [dataWidth-1:0] merged;
    merged = old;
    for (int b = 0; b < strbWidth; b++) begin
      if (strb[b]) merged[8*b +: 8] = data[8*b +: 8];
    end
    return merged;
  endfunction

  function automatic logic [addrWidth-1:0] randomAddr(input int words);
    int word;
    word = ($random(reqSeed) & 32'h7fff_ffff) % words;
    return addrWidth'(word) << 2;
  endfunction

  task automatic reportMismatch(input string msg);
    $display("Mismatch at %0t: %s", $time, msg);
    errorCount++;
  endtask

  task automatic finishTest(input string name, input int errorsBefore);
    testCount++;
    $display("%s test finished at %0t with %0d errors", name, $time, errorCount - errorsBefore);
  endtask

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  always @(posedge aclk) begin : watchdog
    if (cycleCount >= timeoutCycles) begin
      $display("Timeout after %0d cycles, the requests did not all complete", cycleCount);
      $display("*** TEST FAILED ***");
      $finish;
    end else begin
      cycleCount <= cycleCount + 1;
    end
  end

  // memory-backed slave whose random ready values delay each handshake
  always @(posedge aclk) begin : slaveModel
    int word;
    if (reset) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      arready <= 1'b0;
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
      gotAw   = 1'b0;
      gotW    = 1'b0;
      gotAr   = 1'b0;
    end else begin
      awready <= 1'($random(slaveSeed));
      wready  <= 1'($random(slaveSeed));
      arready <= 1'($random(slaveSeed));
      if (awvalid && awready) begin
        slvAwAddr = awaddr;
        gotAw     = 1'b1;
      end
      if (wvalid && wready) begin
        slvWData = wdata;
        slvWStrb = wstrb;
        gotW     = 1'b1;
      end
      if (arvalid && arready) begin
        slvArAddr = araddr;
        gotAr     = 1'b1;
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end else if (gotAw && gotW && !bvalid && ($random(slaveSeed) & 1)) begin
        word = slvAwAddr[7:2];
        if (word < errWord) slaveMem[word] = mergeBytes(slaveMem[word], slvWData, slvWStrb);
        bresp  <= (word < errWord) ? respOkay : respSlvErr;
        bvalid <= 1'b1;
        gotAw  = 1'b0;
        gotW   = 1'b0;
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end else if (gotAr && !rvalid && ($random(slaveSeed) & 1)) begin
        word = slvArAddr[7:2];
        rdata  <= slaveMem[word]; // error reads still return the stored word
        rresp  <= (word < errWord) ? respOkay : respSlvErr;
        rvalid <= 1'b1;
        gotAr  = 1'b0;
      end
    end
  end

  // the reference memory follows the responses since only one transaction is in flight
  always @(posedge aclk) begin : monitor
    wrReqT      w;
    rdReqT      r;
    int         word;
    logic [1:0] expResp;
    if (reset) begin
      rrCheck <= 1'b0;
      awHold  <= 1'b0;
      wHold   <= 1'b0;
      arHold  <= 1'b0;
    end else begin
      if (wrCredit) wrReturned <= wrReturned + 1;
      if (rdCredit) rdReturned <= rdReturned + 1;
      if (awHold) begin
        checkCount++;
        assert (awvalid && awaddr == awaddrLast)
          else reportMismatch("awvalid or awaddr changed before awready");
      end
      if (wHold) begin
        checkCount++;
        assert (wvalid && wdata == wdataLast && wstrb == wstrbLast)
          else reportMismatch("wvalid, wdata or wstrb changed before wready");
      end
      if (arHold) begin
        checkCount++;
        assert (arvalid && araddr == araddrLast)
          else reportMismatch("arvalid or araddr changed before arready");
      end
      if (awvalid || arvalid) begin
        checkCount++;
        assert (awprot == 3'b000 && arprot == 3'b000)
          else reportMismatch("awprot or arprot is not zero during an address phase");
      end
      awHold     <= awvalid && !awready;
      wHold      <= wvalid && !wready;
      arHold     <= arvalid && !arready;
      awaddrLast <= awaddr;
      wdataLast  <= wdata;
      wstrbLast  <= wstrb;
      araddrLast <= araddr;
      if (rspValid) begin
        checkCount++;
        assert (!rrCheck || rspIsWrite == rrExpectWrite)
          else reportMismatch("response kind breaks the round-robin order");
        kindLog.push_back(rspIsWrite);
        if (rspIsWrite && wrDoneCount < wrIssued) begin
          w       = wrLog[wrDoneCount];
          word    = w.addr[7:2];
          expResp = (word >= errWord) ? respSlvErr : respOkay;
          checkCount++;
          assert (rspResp == expResp && rspData == '0)
            else reportMismatch($sformatf("write 0x%08h got resp %0d data 0x%08h, expected %0d",
                                          w.addr, rspResp, rspData, expResp));
          if (expResp == respOkay) refMem[word] = mergeBytes(refMem[word], w.data, w.strb);
          wrDoneCount <= wrDoneCount + 1;
        end else if (!rspIsWrite && rdDoneCount < rdIssued) begin
          r       = rdLog[rdDoneCount];
          word    = r.addr[7:2];
          expResp = (word >= errWord) ? respSlvErr : respOkay;
          checkCount++;
          assert (rspResp == expResp && rspData == refMem[word])
            else reportMismatch($sformatf("read 0x%08h got 0x%08h resp %0d, expected 0x%08h %0d",
                                          r.addr, rspData, rspResp, refMem[word], expResp));
          rdDoneCount <= rdDoneCount + 1;
        end else begin
          $display("Error at %0t: a response arrived with no request of its kind pending", $time);
          errorCount++;
        end
        // both queues still hold work, so the other kind must be served next
        rrCheck <= (wrIssued - wrDoneCount - rspIsWrite > 0) &&
                   (rdIssued - rdDoneCount - !rspIsWrite > 0);
        rrExpectWrite <= !rspIsWrite;
      end
    end
  end

  task automatic sendCycle(input bit wantWr, input wrReqT w, input bit wantRd, input rdReqT r,
                           output bit sentWr, output bit sentRd);
    @(posedge aclk);
    sentWr = wantWr && (queueDepth + wrReturned - wrSpent > 0);
    sentRd = wantRd && (queueDepth + rdReturned - rdSpent > 0);
    wrReqValid <= sentWr;
    wrReqAddr  <= w.addr;
    wrReqData  <= w.data;
    wrReqStrb  <= w.strb;
    rdReqValid <= sentRd;
    rdReqAddr  <= r.addr;
    if (sentWr) begin
      wrSpent++;
      wrLog.push_back(w);
    end
    if (sentRd) begin
      rdSpent++;
      rdLog.push_back(r);
    end
    wrIssued <= wrSpent;
    rdIssued <= rdSpent;
  endtask

  task automatic waitIdle();
    while (wrDoneCount != wrSpent || rdDoneCount != rdSpent) @(posedge aclk);
  endtask

  task automatic sendOne(input bit isWrite, input wrReqT w, input rdReqT r);
    bit sentWr;
    bit sentRd;
    sentWr = 1'b0;
    sentRd = 1'b0;
    while (!(sentWr || sentRd)) sendCycle(isWrite, w, !isWrite, r, sentWr, sentRd);
    sendCycle(1'b0, w, 1'b0, r, sentWr, sentRd);
    waitIdle();
  endtask

  task automatic resetTest();
    int errorsBefore;
    errorsBefore = errorCount;
    @(posedge aclk);
    checkCount++;
    assert ({awvalid, wvalid, arvalid, bready, rready, rspValid, wrCredit, rdCredit} == '0)
      else reportMismatch("valid, ready, response or credit output high after reset");
    finishTest("reset", errorsBefore);
  endtask

  task automatic roundRobinTest();
    int    errorsBefore;
    int    firstIdx;
    int    wrLeft;
    int    rdLeft;
    bit    sentWr;
    bit    sentRd;
    wrReqT w;
    rdReqT r;
    errorsBefore = errorCount;
    firstIdx     = kindLog.size();
    wrLeft       = rrPairs;
    rdLeft       = rrPairs;
    while (wrLeft > 0 || rdLeft > 0) begin
      w.addr = randomAddr(errWord);
      w.data = $random(reqSeed);
      w.strb = strbWidth'($random(reqSeed));
      r.addr = randomAddr(errWord);
      sendCycle(wrLeft > 0, w, rdLeft > 0, r, sentWr, sentRd);
      wrLeft -= sentWr;
      rdLeft -= sentRd;
    end
    sendCycle(1'b0, w, 1'b0, r, sentWr, sentRd);
    waitIdle();
    for (int i = 0; i < 2 * rrPairs; i++) begin
      checkCount++;
      assert (kindLog[firstIdx + i] == !i[0])
        else reportMismatch($sformatf("response %0d should be a %s", i, i[0] ? "read" : "write"));
    end
    finishTest("round robin", errorsBefore);
  endtask

  task automatic writeReadTest();
    int    errorsBefore;
    wrReqT w;
    rdReqT r;
    errorsBefore = errorCount;
    for (int i = 0; i < pairTests; i++) begin
      w.addr = randomAddr(errWord);
      w.data = $random(reqSeed);
      w.strb = strbWidth'($random(reqSeed));
      r.addr = w.addr;
      sendOne(1'b1, w, r);
      sendOne(1'b0, w, r);
    end
    finishTest("write then read", errorsBefore);
  endtask

  task automatic burstTest();
    int         errorsBefore;
    int         left;
    logic [1:0] pick;
    bit         sentWr;
    bit         sentRd;
    wrReqT      w;
    rdReqT      r;
    errorsBefore = errorCount;
    left         = burstLen;
    while (left > 0) begin
      w.addr = randomAddr(memWords);
      w.data = $random(reqSeed);
      w.strb = strbWidth'($random(reqSeed));
      r.addr = randomAddr(memWords);
      pick   = 2'($random(reqSeed));
      sendCycle(pick[0], w, pick[1] && left > 1, r, sentWr, sentRd);
      left -= sentWr + sentRd;
    end
    sendCycle(1'b0, w, 1'b0, r, sentWr, sentRd);
    waitIdle();
    repeat (10) @(posedge aclk);
    checkCount++;
    assert (wrReturned == wrDoneCount && rdReturned == rdDoneCount)
      else reportMismatch($sformatf("credits %0d/%0d but pops %0d/%0d",
                                    wrReturned, rdReturned, wrDoneCount, rdDoneCount));
    finishTest("burst", errorsBefore);
  endtask

  task automatic errorTest();
    int    errorsBefore;
    wrReqT w;
    rdReqT r;
    errorsBefore = errorCount;
    w.addr = addrWidth'(errWord + 2) << 2;
    w.data = $random(reqSeed);
    w.strb = 4'hf;
    r.addr = w.addr;
    sendOne(1'b1, w, r);
    sendOne(1'b0, w, r); // monitor expects SLVERR and the untouched fill word
    finishTest("error range", errorsBefore);
  endtask

  initial begin
    for (int i = 0; i < memWords; i++) begin
      slaveMem[i] = fillWord(i);
      refMem[i]   = fillWord(i);
    end
    reset      = 1'b1;
    wrReqValid = 1'b0;
    rdReqValid = 1'b0;
    wrReqAddr  = '0;
    wrReqData  = '0;
    wrReqStrb  = '0;
    rdReqAddr  = '0;
    {awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp} = '0;
    repeat (3) @(posedge aclk);
    reset <= 1'b0;
    resetTest();
    roundRobinTest();
    writeReadTest();
    burstTest();
    errorTest();
    $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule : tbAxiLiteMaster

// File: sources.f
design/axiLitePkg.sv
design/masterReqPkg.sv
design/creditFifo.sv
design/writeChannel.sv
design/readChannel.sv
design/masterControl.sv
design/axiLiteMasterTop.sv
testbench/tbAxiLiteMaster.sv

// File: Bender.yml
package:
  name: axiLiteMaster

sources:
  - design/axiLitePkg.sv
  - design/masterReqPkg.sv
  - design/creditFifo.sv
  - design/writeChannel.sv
  - design/readChannel.sv
  - design/masterControl.sv
  - design/axiLiteMasterTop.sv
  - target: test
    files:
      - testbench/tbAxiLiteMaster.sv
